// File: hdl/soc_io_params.svh
`ifndef SOC_IO_PARAMS_SVH
`define SOC_IO_PARAMS_SVH

// ------------------------------------------------------------
// address map
// ------------------------------------------------------------

`define SCR_REGION    16'h0010     // upper 16 bits, scratch memory
`define REG_PAGE_LT   24'hFD0FFF   // upper 24 bits, led and timer page
`define REG_PAGE_RNG  24'hFD0FFD   // upper 24 bits, random page

// ------------------------------------------------------------
// random number generator
// ------------------------------------------------------------

`define RNG_SEED      32'h2545F491 // must never be zero
// right-shift galois form of x^32 + x^22 + x^2 + x + 1
`define RNG_TAPS      32'h80200003

// ------------------------------------------------------------
// timer, in node_clk cycles
// ------------------------------------------------------------

`define TICK_PERIOD   100
`define TICK_ON       30           // irq rises here
`define TICK_OFF      40           // and falls here

`endif

// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

	// data word and byte lane enables of the node bus
	typedef logic [31:0] bus_word_t;
	typedef logic [3:0]  bus_sel_t;

	// memory style view
	// 64k regions, the scratch memory sits in one of them
	typedef struct packed {
		logic [15:0] hi;   // region number
		logic [15:0] ofs;  // byte offset inside the region
	} bus_region_t;

	// register block view
	// 256 byte pages of device registers
	typedef struct packed {
		logic [23:0] hi;   // page number
		logic [7:0]  ofs;  // register offset
	} bus_page_t;

	// one address word, decoded either way
	typedef union packed {
		bus_region_t region;
		bus_page_t   page;
	} bus_addr_u;

endpackage

// File: hdl/soc_map_pkg.sv
package soc_map_pkg;

	// device hit by an address
	typedef enum logic [1:0] {
		dev_scratch,
		dev_lt,
		dev_rng,
		dev_none        // unmapped, answered with a bus error
	} dev_id_e;

	// one-hot chip selects, registered with the request
	typedef struct packed {
		logic scratch;
		logic lt;
		logic rng;
	} dev_sel_t;

	// device reply, dat is zero unless ack is set
	typedef struct packed {
		logic                   ack;
		soc_bus_pkg::bus_word_t dat;
	} dev_resp_t;

endpackage

// File: hdl/io_bus_if.sv
`timescale 1ns/1ps

// decoded request from the decoder to the io devices
interface io_bus_if;

	logic                   stb;     // one cycle per access
	logic                   we;
	soc_bus_pkg::bus_sel_t  sel;
	soc_bus_pkg::bus_addr_u adr;
	soc_bus_pkg::bus_word_t dat;     // write data
	soc_map_pkg::dev_sel_t  dev_sel;

	modport decoder (
		output stb, we, sel, adr, dat, dev_sel
	);

	modport device (
		input stb, we, sel, adr, dat, dev_sel
	);

endinterface

// File: hdl/io_decoder.sv
`timescale 1ns/1ps
`include "soc_io_params.svh"

module io_decoder (
	input  logic                   node_clk,
	input  logic                   rst,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  soc_bus_pkg::bus_sel_t  sel_i,
	input  soc_bus_pkg::bus_addr_u adr_i,
	input  soc_bus_pkg::bus_word_t dat_i,
	input  soc_map_pkg::dev_resp_t scr_resp_i,
	input  soc_map_pkg::dev_resp_t lt_resp_i,
	input  soc_map_pkg::dev_resp_t rng_resp_i,
	output soc_bus_pkg::bus_word_t dat_o,
	output logic                   ack_o,
	output logic                   err_o,
	io_bus_if.decoder              bus
);

	soc_map_pkg::dev_id_e  dev_id;
	soc_map_pkg::dev_sel_t dev_sel;
	logic                  req;
	logic                  err_q;   // unmapped strobe, one cycle old

	assign req = cyc_i & stb_i;

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------

	always_comb begin
		if (adr_i.region.hi == `SCR_REGION)
			dev_id = soc_map_pkg::dev_scratch;
		else if (adr_i.page.hi == `REG_PAGE_LT)
			dev_id = soc_map_pkg::dev_lt;
		else if (adr_i.page.hi == `REG_PAGE_RNG)
			dev_id = soc_map_pkg::dev_rng;
		else
			dev_id = soc_map_pkg::dev_none;
	end

	always_comb begin
		dev_sel.scratch = req & (dev_id == soc_map_pkg::dev_scratch);
		dev_sel.lt      = req & (dev_id == soc_map_pkg::dev_lt);
		dev_sel.rng     = req & (dev_id == soc_map_pkg::dev_rng);
	end

	// request register, first cycle of the access
	always_ff @(posedge node_clk) begin
		if (rst) begin
			bus.stb     <= 1'b0;
			bus.dev_sel <= '0;
			err_q       <= 1'b0;
		end else begin
			bus.stb     <= req;
			bus.dev_sel <= dev_sel;
			err_q       <= req & (dev_id == soc_map_pkg::dev_none);
		end
	end

	always_ff @(posedge node_clk) begin
		if (req) begin   // payload only moves with a strobe
			bus.we  <= we_i;
			bus.sel <= sel_i;
			bus.adr <= adr_i;
			bus.dat <= dat_i;
		end
	end

	// ------------------------------------------------------------
	// response register, devices zero their data when idle
	// ------------------------------------------------------------

	always_ff @(posedge node_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			dat_o <= '0;
		end else begin
			ack_o <= scr_resp_i.ack | lt_resp_i.ack | rng_resp_i.ack;
			dat_o <= scr_resp_i.dat | lt_resp_i.dat | rng_resp_i.dat;
			err_o <= err_q;   // lines up with ack timing
		end
	end

endmodule

// File: hdl/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram (
	input  logic                   node_clk,
	input  logic                   rst,
	io_bus_if.device               bus,
	output soc_map_pkg::dev_resp_t resp_o
);

	soc_bus_pkg::bus_word_t mem [0:255];
	logic [7:0]             idx;
	logic                   hit;
	logic                   wr;

	assign hit = bus.stb & bus.dev_sel.scratch;
	assign wr  = hit & bus.we & ~rst;    // no stores while in reset
	assign idx = bus.adr.region.ofs[9:2];  // word index, region mirrors above 1k

	// byte lane writes
	always_ff @(posedge node_clk) begin
		if (wr) begin
			for (int i = 0; i < 4; i++) begin
				if (bus.sel[i])
					mem[idx][i*8 +: 8] <= bus.dat[i*8 +: 8];
			end
		end
	end

	// read path, captured by the decoder response register
	always_comb begin
		resp_o.ack = hit;
		if (hit & ~bus.we)
			resp_o.dat = mem[idx];
		else
			resp_o.dat = '0;
	end

endmodule

// File: hdl/lfsr_rng.sv
`timescale 1ns/1ps
`include "soc_io_params.svh"

module lfsr_rng (
	input  logic                   node_clk,
	input  logic                   rst,
	io_bus_if.device               bus,
	output soc_map_pkg::dev_resp_t resp_o
);

	soc_bus_pkg::bus_word_t state;
	soc_bus_pkg::bus_word_t next_state;
	logic                   hit;

	assign hit = bus.stb & bus.dev_sel.rng;

	// galois step, taps folded in when a one drops out
	always_comb begin
		next_state = {1'b0, state[31:1]};
		if (state[0])
			next_state = next_state ^ `RNG_TAPS;
	end

	always_ff @(posedge node_clk) begin
		if (rst)
			state <= `RNG_SEED;
		else if (hit) begin
			if (bus.we)
				state <= (bus.dat == '0) ? `RNG_SEED : bus.dat;  // zero would lock up
			else
				state <= next_state;   // every read consumes one value
		end
	end

	// returns the value before the step
	always_comb begin
		resp_o.ack = hit;
		resp_o.dat = (hit & ~bus.we) ? state : '0;
	end

endmodule

// File: hdl/led_timer_regs.sv
`timescale 1ns/1ps
`include "soc_io_params.svh"

module led_timer_regs (
	input  logic                   node_clk,
	input  logic                   rst,
	io_bus_if.device               bus,
	output soc_map_pkg::dev_resp_t resp_o,
	output logic [7:0]             led_o,
	output logic                   tick_irq_o
);

	localparam logic [7:0] ofs_led  = 8'h00;
	localparam logic [7:0] ofs_tick = 8'h04;   // read only

	logic [7:0]             led_q;
	logic [6:0]             cyc_cnt;   // runs 1 to TICK_PERIOD
	logic                   irq_q;
	logic [15:0]            tick_cnt;
	logic                   hit;
	soc_bus_pkg::bus_word_t rd_data;

	assign hit = bus.stb & bus.dev_sel.lt;

	always_ff @(posedge node_clk) begin
		if (rst)
			led_q <= '0;
		else if (hit & bus.we & bus.sel[0] & (bus.adr.page.ofs == ofs_led))
			led_q <= bus.dat[7:0];
	end

	// ------------------------------------------------------------
	// periodic interrupt
	// ------------------------------------------------------------

	always_ff @(posedge node_clk) begin
		if (rst) begin
			cyc_cnt  <= 7'd1;
			irq_q    <= 1'b0;
			tick_cnt <= '0;
		end else begin
			cyc_cnt <= (cyc_cnt == `TICK_PERIOD) ? 7'd1 : cyc_cnt + 7'd1;
			if (cyc_cnt == `TICK_ON) begin
				irq_q    <= 1'b1;
				tick_cnt <= tick_cnt + 16'd1;   // counts rising edges
			end else if (cyc_cnt == `TICK_OFF)
				irq_q <= 1'b0;
		end
	end

	always_comb begin
		case (bus.adr.page.ofs)
			ofs_led:  rd_data = {24'd0, led_q};
			ofs_tick: rd_data = {16'd0, tick_cnt};
			default:  rd_data = '0;
		endcase
		resp_o.ack = hit;
		resp_o.dat = (hit & ~bus.we) ? rd_data : '0;
	end

	assign led_o      = led_q;
	assign tick_irq_o = irq_q;

endmodule

// File: hdl/soc_io.sv
`timescale 1ns/1ps

module soc_io (
	input  logic        node_clk,
	input  logic        rst,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o,
	output logic        err_o,
	output logic [7:0]  led_o,
	output logic        tick_irq_o
);

	io_bus_if bus ();

	soc_map_pkg::dev_resp_t scr_resp;
	soc_map_pkg::dev_resp_t lt_resp;
	soc_map_pkg::dev_resp_t rng_resp;

	// ------------------------------------------------------------
	// decode and response combine
	// ------------------------------------------------------------

	io_decoder u_dec (
		.node_clk   (node_clk),
		.rst        (rst),
		.cyc_i      (cyc_i),
		.stb_i      (stb_i),
		.we_i       (we_i),
		.sel_i      (sel_i),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.scr_resp_i (scr_resp),
		.lt_resp_i  (lt_resp),
		.rng_resp_i (rng_resp),
		.dat_o      (dat_o),
		.ack_o      (ack_o),
		.err_o      (err_o),
		.bus        (bus)
	);

	scratch_ram u_scr (.node_clk(node_clk), .rst(rst), .bus(bus), .resp_o(scr_resp));

	lfsr_rng u_rng (.node_clk(node_clk), .rst(rst), .bus(bus), .resp_o(rng_resp));

	led_timer_regs u_lt (
		.node_clk   (node_clk),
		.rst        (rst),
		.bus        (bus),
		.resp_o     (lt_resp),
		.led_o      (led_o),
		.tick_irq_o (tick_irq_o)
	);

endmodule

// File: verif/soc_io_props.sv
`timescale 1ns/1ps
`include "soc_io_params.svh"

module soc_io_props (
	input logic node_clk,
	input logic rst,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_o,
	input logic err_o,
	input logic tick_irq_o
);

	logic [7:0] irq_len;   // consecutive high samples of the irq

	always_ff @(posedge node_clk) begin
		if (rst)
			irq_len <= '0;
		else if (tick_irq_o)
			irq_len <= irq_len + 8'd1;
		else
			irq_len <= '0;
	end

	ack_err_excl: assert property (@(posedge node_clk) disable iff (rst)
		!(ack_o && err_o))
		else $error("ack_o and err_o high in the same cycle");

	// fixed two cycle latency from strobe to response
	resp_after_stb: assert property (@(posedge node_clk) disable iff (rst)
		(ack_o || err_o) |-> $past(cyc_i && stb_i, 2))
		else $error("response without a strobe two cycles earlier");

	irq_width: assert property (@(posedge node_clk) disable iff (rst)
		$fell(tick_irq_o) |-> irq_len == (`TICK_OFF - `TICK_ON))
		else $error("tick_irq_o high for %0d cycles", irq_len);

endmodule

bind soc_io soc_io_props u_props (
	.node_clk   (node_clk),
	.rst        (rst),
	.cyc_i      (cyc_i),
	.stb_i      (stb_i),
	.ack_o      (ack_o),
	.err_o      (err_o),
	.tick_irq_o (tick_irq_o)
);

// File: verif/soc_io_tb.sv
`timescale 1ns/1ps
`include "soc_io_params.svh"

module soc_io_tb;

	typedef struct {
		string                  name;
		logic                   we;
		soc_bus_pkg::bus_sel_t  sel;
		soc_bus_pkg::bus_addr_u adr;
		soc_bus_pkg::bus_word_t dat;
		logic                   exp_err;
		soc_bus_pkg::bus_word_t exp_dat;
		logic [7:0]             exp_led;   // led_o once the access is done
		logic                   tick;      // wait for an irq rise and expect the count
	} row_t;

	logic                   node_clk;
	logic                   rst;
	logic                   cyc_i;
	logic                   stb_i;
	logic                   we_i;
	soc_bus_pkg::bus_sel_t  sel_i;
	soc_bus_pkg::bus_addr_u adr_i;
	soc_bus_pkg::bus_word_t dat_i;
	soc_bus_pkg::bus_word_t dat_o;
	logic                   ack_o;
	logic                   err_o;
	logic [7:0]             led_o;
	logic                   tick_irq_o;

	row_t                   rows[$];
	int                     n_rows = 0;
	int                     errors = 0;
	soc_bus_pkg::bus_word_t scr_m [0:255];   // scratch model
	soc_bus_pkg::bus_word_t lfsr_m;
	logic [7:0]             led_m;
	int                     rises;
	int                     hi_run;
	int                     since_rise;
	logic                   irq_prev;

	soc_io UUT (
		.node_clk   (node_clk),
		.rst        (rst),
		.cyc_i      (cyc_i),
		.stb_i      (stb_i),
		.we_i       (we_i),
		.sel_i      (sel_i),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.dat_o      (dat_o),
		.ack_o      (ack_o),
		.err_o      (err_o),
		.led_o      (led_o),
		.tick_irq_o (tick_irq_o)
	);

	always #5 node_clk = ~node_clk;

	task automatic compare_word(string name, soc_bus_pkg::bus_word_t exp,
			soc_bus_pkg::bus_word_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_flag(string name, string what, logic exp, logic act);
		if (exp !== act) begin
			$display("MISMATCH %s %s: expected %0b, actual %0b", name, what, exp, act);
			errors++;
		end
	endtask

	// one step of the right-shift galois lfsr
	function automatic soc_bus_pkg::bus_word_t lfsr_next(soc_bus_pkg::bus_word_t s);
		soc_bus_pkg::bus_word_t n;
		n = s >> 1;
		if (s[0])
			n = n ^ `RNG_TAPS;
		return n;
	endfunction

	// ------------------------------------------------------------
	// stimulus table with expected values from the device models
	// ------------------------------------------------------------

	function automatic void add_row(string name, logic we, soc_bus_pkg::bus_sel_t sel,
			soc_bus_pkg::bus_addr_u adr, soc_bus_pkg::bus_word_t dat, logic tick);
		row_t r;
		r.name    = name;
		r.we      = we;
		r.sel     = sel;
		r.adr     = adr;
		r.dat     = dat;
		r.tick    = tick;
		r.exp_err = 1'b0;
		r.exp_dat = '0;
		if (adr.region.hi == `SCR_REGION) begin
			if (we) begin
				for (int b = 0; b < 4; b++) begin
					if (sel[b])
						scr_m[adr.region.ofs[9:2]][b*8 +: 8] = dat[b*8 +: 8];
				end
			end else
				r.exp_dat = scr_m[adr.region.ofs[9:2]];
		end else if (adr.page.hi == `REG_PAGE_LT) begin
			if (we && sel[0] && adr.page.ofs == 8'h00)
				led_m = dat[7:0];
			else if (!we && adr.page.ofs == 8'h00)
				r.exp_dat = {24'd0, led_m};
		end else if (adr.page.hi == `REG_PAGE_RNG) begin
			if (we)
				lfsr_m = (dat == '0) ? `RNG_SEED : dat;
			else begin
				r.exp_dat = lfsr_m;
				lfsr_m    = lfsr_next(lfsr_m);
			end
		end else
			r.exp_err = 1'b1;   // nothing mapped here
		r.exp_led = led_m;
		rows.push_back(r);
	endfunction

	task automatic build_table();
		soc_bus_pkg::bus_word_t a;
		logic [15:0]            masks;
		masks  = 16'h83A5;   // 0101, 1010, 0011, 1000
		lfsr_m = `RNG_SEED;
		led_m  = '0;
		for (int k = 0; k < 4; k++) begin
			a = 32'h0010_0000 + k * 32'h44;
			add_row($sformatf("scr_fill%0d", k), 1'b1, 4'hF, a, $urandom, 1'b0);
			add_row($sformatf("scr_merge%0d", k), 1'b1, masks[k*4 +: 4], a, $urandom, 1'b0);
			add_row($sformatf("scr_read%0d", k), 1'b0, 4'hF, a, '0, 1'b0);
		end
		add_row("led_wr", 1'b1, 4'h1, 32'hFD0F_FF00, 32'h0000_00A5, 1'b0);
		add_row("led_rd", 1'b0, 4'hF, 32'hFD0F_FF00, '0, 1'b0);
		for (int k = 0; k < 3; k++)
			add_row($sformatf("rng_rd%0d", k), 1'b0, 4'hF, 32'hFD0F_FD00, '0, 1'b0);
		add_row("rng_seed", 1'b1, 4'hF, 32'hFD0F_FD00, 32'h1234_5678, 1'b0);
		add_row("rng_seed_rd0", 1'b0, 4'hF, 32'hFD0F_FD00, '0, 1'b0);
		add_row("rng_seed_rd1", 1'b0, 4'hF, 32'hFD0F_FD00, '0, 1'b0);
		add_row("rng_zero", 1'b1, 4'hF, 32'hFD0F_FD00, '0, 1'b0);
		add_row("rng_zero_rd0", 1'b0, 4'hF, 32'hFD0F_FD00, '0, 1'b0);
		add_row("rng_zero_rd1", 1'b0, 4'hF, 32'hFD0F_FD00, '0, 1'b0);
		add_row("unmapped_rd", 1'b0, 4'hF, 32'h0000_1000, '0, 1'b0);
		add_row("unmapped_wr", 1'b1, 4'hF, 32'hFD0F_FE00, 32'hDEAD_BEEF, 1'b0);
		add_row("tick_cnt0", 1'b0, 4'hF, 32'hFD0F_FF04, '0, 1'b1);
		add_row("tick_cnt1", 1'b0, 4'hF, 32'hFD0F_FF04, '0, 1'b1);
		n_rows = rows.size();
	endtask

	// one strobe with the response exactly two cycles later
	task automatic apply_row(row_t r);
		int n;
		if (r.tick) begin
			n = rises;
			wait (rises > n);
			#1;
			r.exp_dat = rises;
		end
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = r.we;
		sel_i = r.sel;
		adr_i = r.adr;
		dat_i = r.dat;
		@(posedge node_clk);
		#1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		compare_flag(r.name, "ack early", 1'b0, ack_o);
		compare_flag(r.name, "err early", 1'b0, err_o);
		compare_word({r.name, " dat early"}, '0, dat_o);
		@(posedge node_clk);
		#1;
		compare_flag(r.name, "ack", ~r.exp_err, ack_o);
		compare_flag(r.name, "err", r.exp_err, err_o);
		compare_word(r.name, r.exp_dat, dat_o);
		compare_word({r.name, " led_o"}, {24'd0, r.exp_led}, {24'd0, led_o});
		@(posedge node_clk);
		#1;
		compare_flag(r.name, "ack end", 1'b0, ack_o);   // single cycle pulse
		compare_flag(r.name, "err end", 1'b0, err_o);
		compare_word({r.name, " dat end"}, '0, dat_o);   // zero outside the ack
	endtask

	// ------------------------------------------------------------
	// timer monitor sampling irq at each rising edge
	// ------------------------------------------------------------

	always @(posedge node_clk) begin
		if (rst) begin
			irq_prev   = 1'b0;
			rises      = 0;
			hi_run     = 0;
			since_rise = 0;
		end else begin
			since_rise++;
			if (tick_irq_o)
				hi_run++;
			if (tick_irq_o && !irq_prev) begin
				if (rises > 0)
					compare_word("irq_period", `TICK_PERIOD, since_rise);
				rises++;
				since_rise = 0;
			end else if (!tick_irq_o && irq_prev) begin
				compare_word("irq_high", `TICK_OFF - `TICK_ON, hi_run);
				hi_run = 0;
			end
			irq_prev = tick_irq_o;
		end
	end

	initial begin
		wait (n_rows > 0);
		repeat (n_rows * 10 + 500) @(posedge node_clk);
		$display("watchdog expired, the row loop did not finish in %0d cycles",
			n_rows * 10 + 500);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(86));
		node_clk = 1'b0;
		rst      = 1'b1;
		cyc_i    = 1'b0;
		stb_i    = 1'b0;
		we_i     = 1'b0;
		sel_i    = '0;
		adr_i    = '0;
		dat_i    = '0;
		build_table();
		repeat (16) @(posedge node_clk);
		#1;
		rst = 1'b0;
		foreach (rows[i])
			apply_row(rows[i]);
		$display("soc_io_tb finished, %0d rows, %0d errors", n_rows, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: soc_io.f
+incdir+hdl
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/io_bus_if.sv
hdl/io_decoder.sv
hdl/scratch_ram.sv
hdl/lfsr_rng.sv
hdl/led_timer_regs.sv
hdl/soc_io.sv
verif/soc_io_props.sv
verif/soc_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the soc_io testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module soc_io_tb \
	-f soc_io.f -o soc_io_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/soc_io_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0
